// File: fdtd_pkg.sv
`default_nettype none

package fdtd_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // byte address and field word
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // byte offset inside one word
    localparam int OFFS_W = 2;

    // one Hy or Ez value
    typedef logic [DATA_W-1:0] word_t;

    // word index, byte address without the offset bits
    typedef logic [ADDR_W-OFFS_W-1:0] word_addr_t;

    //////////////////////////////
    // addresses
    //////////////////////////////

    // word index over byte offset
    typedef struct packed {
        word_addr_t        word;
        logic [OFFS_W-1:0] offs;
    } addr_fields_t;

    // same address seen as a raw byte address or as index and offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } addr_u;

    // which field a phase works on
    typedef enum logic {
        FIELD_HY = 1'b0,
        FIELD_EZ = 1'b1
    } field_e;

    // memory word port
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        word_t             data;
    } mem_wr_req_t;

    // fsm command to the address generator and the word port
    typedef struct packed {
        logic   rd_active;
        field_e rd_field;
        logic   wr_active;
        field_e wr_field;
        logic   load;
    } seq_cmd_t;

endpackage

`default_nettype wire

// File: fdtd_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_seq_fsm
    import fdtd_pkg::*;
(
    input  wire logic ACLK,
    input  wire logic ARESETn,
    input  wire logic fdtd_start_i,
    input  wire logic calc_hy_en_i,
    input  wire logic calc_ez_en_i,
    input  wire logic wrt_start_i,
    input  wire logic rd_gnt_i,
    input  wire logic wr_gnt_i,
    input  wire logic chunk_last_i,
    input  wire logic run_empty_i,
    output seq_cmd_t  cmd_o,
    output logic      calc_hy_flg_o,
    output logic      calc_ez_flg_o,
    output logic      buffer_end_o,
    output logic      busy_o,
    output logic      field_done_o,
    output field_e    done_field_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_HY,
        S_RD_EZ,
        S_AWAIT_CHOICE,
        S_AWAIT_WRT,
        S_WRITE,
        S_DONE
    } state_e;

    state_e state_q;
    state_e state_n;
    field_e field_q;
    field_e field_n;

    // low in the first cycle of every state
    logic   phase_go_q;

    //////////////////////////////
    // state registers
    //////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q    <= S_IDLE;
            phase_go_q <= 1'b0;
            field_q    <= FIELD_HY;
        end
        else
        begin
            state_q    <= state_n;
            phase_go_q <= (state_n == state_q);
            field_q    <= field_n;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb
    begin
        state_n       = state_q;
        field_n       = field_q;
        calc_hy_flg_o = 1'b0;
        calc_ez_flg_o = 1'b0;
        buffer_end_o  = 1'b0;
        field_done_o  = 1'b0;
        case (state_q)
            S_IDLE:
            begin
                if (fdtd_start_i)
                    state_n = S_RD_HY;
            end
            S_RD_HY:
            begin
                if (rd_gnt_i && chunk_last_i)
                    state_n = S_RD_EZ;
            end
            S_RD_EZ:
            begin
                if (rd_gnt_i && chunk_last_i)
                    state_n = S_AWAIT_CHOICE;
            end
            S_AWAIT_CHOICE:
            begin
                buffer_end_o = 1'b1;
                // Hy has priority over Ez
                if (calc_hy_en_i)
                begin
                    calc_hy_flg_o = 1'b1;
                    field_n       = FIELD_HY;
                    state_n       = S_AWAIT_WRT;
                end
                else if (calc_ez_en_i)
                begin
                    calc_ez_flg_o = 1'b1;
                    field_n       = FIELD_EZ;
                    state_n       = S_AWAIT_WRT;
                end
            end
            S_AWAIT_WRT:
            begin
                buffer_end_o = 1'b1;
                if (wrt_start_i)
                    state_n = S_WRITE;
            end
            S_WRITE:
            begin
                if (wr_gnt_i && chunk_last_i)
                    state_n = S_DONE;
            end
            S_DONE:
            begin
                // remaining count is settled here
                if (run_empty_i)
                begin
                    field_done_o = 1'b1;
                    state_n      = S_IDLE;
                end
                else
                    state_n = S_RD_HY;
            end
            default:
                state_n = S_IDLE;
        endcase
    end

    // requests start one cycle into a phase
    always_comb
    begin
        cmd_o.rd_active = phase_go_q && (state_q == S_RD_HY || state_q == S_RD_EZ);
        cmd_o.rd_field  = (state_q == S_RD_EZ) ? FIELD_EZ : FIELD_HY;
        cmd_o.wr_active = phase_go_q && (state_q == S_WRITE);
        cmd_o.wr_field  = field_q;
        cmd_o.load      = (state_q == S_IDLE) && fdtd_start_i;
    end

    assign busy_o       = (state_q != S_IDLE);
    assign done_field_o = field_q;

endmodule

`default_nettype wire

// File: fdtd_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_addr_gen
    import fdtd_pkg::*;
#(
    parameter int BUFFER_SIZE = 50,
    parameter int SIZE_W      = 16
)
(
    input  wire logic              ACLK,
    input  wire logic              ARESETn,
    input  wire seq_cmd_t          cmd_i,
    input  wire word_addr_t        hy_word_i,
    input  wire word_addr_t        ez_word_i,
    input  wire logic [SIZE_W-1:0] size_i,
    input  wire logic              rd_gnt_i,
    input  wire logic              wr_gnt_i,
    output word_addr_t             rd_addr_o,
    output word_addr_t             wr_addr_o,
    output logic                   chunk_last_o,
    output logic                   run_empty_o
);

    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    word_addr_t        hy_rd_q;
    word_addr_t        ez_rd_q;
    word_addr_t        hy_wr_q;
    word_addr_t        ez_wr_q;
    logic [SIZE_W-1:0] remain_q;
    logic [CNT_W-1:0]  chunk_cnt_q;
    logic [SIZE_W-1:0] left;
    logic              phase_on;

    assign phase_on = cmd_i.rd_active || cmd_i.wr_active;

    //////////////////////////////
    // run and chunk counters
    //////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            remain_q    <= '0;
            chunk_cnt_q <= '0;
        end
        else
        begin
            if (cmd_i.load)
                remain_q <= size_i;
            else if (wr_gnt_i)
                remain_q <= remain_q - 1'b1;
            // settle cycle between phases clears the count
            if (!phase_on)
                chunk_cnt_q <= '0;
            else if (rd_gnt_i || wr_gnt_i)
                chunk_cnt_q <= chunk_cnt_q + 1'b1;
        end
    end

    // word pointers per field
    always_ff @(posedge ACLK)
    begin
        if (cmd_i.load)
        begin
            hy_rd_q <= hy_word_i;
            ez_rd_q <= ez_word_i;
            hy_wr_q <= hy_word_i;
            ez_wr_q <= ez_word_i;
        end
        else
        begin
            if (rd_gnt_i && cmd_i.rd_field == FIELD_HY)
                hy_rd_q <= hy_rd_q + 1'b1;
            if (rd_gnt_i && cmd_i.rd_field == FIELD_EZ)
                ez_rd_q <= ez_rd_q + 1'b1;
            if (wr_gnt_i && cmd_i.wr_field == FIELD_HY)
                hy_wr_q <= hy_wr_q + 1'b1;
            if (wr_gnt_i && cmd_i.wr_field == FIELD_EZ)
                ez_wr_q <= ez_wr_q + 1'b1;
        end
    end

    assign rd_addr_o = (cmd_i.rd_field == FIELD_HY) ? hy_rd_q : ez_rd_q;
    assign wr_addr_o = (cmd_i.wr_field == FIELD_HY) ? hy_wr_q : ez_wr_q;

    // words still uncovered, remain_q only moves during writes
    assign left = cmd_i.wr_active ? remain_q : remain_q - SIZE_W'(chunk_cnt_q);

    assign chunk_last_o = (chunk_cnt_q == CNT_W'(BUFFER_SIZE - 1)) || (left == SIZE_W'(1));
    assign run_empty_o  = (remain_q == '0);

endmodule

`default_nettype wire

// File: fdtd_word_port.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_word_port
    import fdtd_pkg::*;
(
    input  wire seq_cmd_t   cmd_i,
    input  wire word_addr_t rd_addr_i,
    input  wire word_addr_t wr_addr_i,
    input  wire word_t      hy_new_i,
    input  wire word_t      ez_new_i,
    input  wire logic       mem_rd_gnt_i,
    input  wire word_t      mem_rd_data_i,
    input  wire logic       mem_wr_gnt_i,
    output mem_rd_req_t     mem_rd_o,
    output mem_wr_req_t     mem_wr_o,
    output logic            rd_gnt_o,
    output logic            wr_gnt_o,
    output word_t           hy_old_o,
    output word_t           ez_old_o,
    output logic            rdvalid_hy_o,
    output logic            rdvalid_ez_o,
    output logic            wrtvalid_o
);

    addr_u rd_byte;
    addr_u wr_byte;
    logic  rd_hy_sel;
    logic  rd_ez_sel;

    // word index to byte address, offset always zero
    always_comb
    begin
        rd_byte.f.word = rd_addr_i;
        rd_byte.f.offs = '0;
        wr_byte.f.word = wr_addr_i;
        wr_byte.f.offs = '0;
    end

    // request flags follow the active phase
    always_comb
    begin
        mem_rd_o.req  = cmd_i.rd_active;
        mem_rd_o.addr = rd_byte.raw;
        mem_wr_o.req  = cmd_i.wr_active;
        mem_wr_o.addr = wr_byte.raw;
        mem_wr_o.data = (cmd_i.wr_field == FIELD_HY) ? hy_new_i : ez_new_i;
    end

    assign rd_gnt_o = cmd_i.rd_active && mem_rd_gnt_i;
    assign wr_gnt_o = cmd_i.wr_active && mem_wr_gnt_i;

    // granted read word goes to the field being read
    assign rd_hy_sel = rd_gnt_o && (cmd_i.rd_field == FIELD_HY);
    assign rd_ez_sel = rd_gnt_o && (cmd_i.rd_field == FIELD_EZ);

    assign hy_old_o     = rd_hy_sel ? mem_rd_data_i : '0;
    assign ez_old_o     = rd_ez_sel ? mem_rd_data_i : '0;
    assign rdvalid_hy_o = rd_hy_sel;
    assign rdvalid_ez_o = rd_ez_sel;

    // engine advances to its next new value
    assign wrtvalid_o = wr_gnt_o;

endmodule

`default_nettype wire

// File: fdtd_status.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_status
    import fdtd_pkg::*;
(
    input  wire logic   ACLK,
    input  wire logic   ARESETn,
    input  wire logic   busy_i,
    input  wire logic   field_done_i,
    input  wire field_e done_field_i,
    input  wire logic   calc_hy_en_i,
    input  wire logic   calc_ez_en_i,
    input  wire logic   ctrl_int_en_i,
    input  wire logic   cmd_clr_int_i,
    output logic        status_int_pending_o,
    output logic        int_o,
    output logic        calc_hy_end_o,
    output logic        calc_ez_end_o
);

    logic busy_q;

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q               <= 1'b0;
            status_int_pending_o <= 1'b0;
            calc_hy_end_o        <= 1'b0;
            calc_ez_end_o        <= 1'b0;
        end
        else
        begin
            busy_q <= busy_i;
            // clear beats a new falling edge
            if (cmd_clr_int_i)
                status_int_pending_o <= 1'b0;
            else if (busy_q && !busy_i)
                status_int_pending_o <= 1'b1;
            // end flags hand off to the other field
            if (field_done_i && done_field_i == FIELD_HY)
                calc_hy_end_o <= 1'b1;
            else if (calc_ez_en_i)
                calc_hy_end_o <= 1'b0;
            if (field_done_i && done_field_i == FIELD_EZ)
                calc_ez_end_o <= 1'b1;
            else if (calc_hy_en_i)
                calc_ez_end_o <= 1'b0;
        end
    end

    assign int_o = status_int_pending_o && ctrl_int_en_i;

endmodule

`default_nettype wire

// File: fdtd_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl
    import fdtd_pkg::*;
#(
    parameter int BUFFER_SIZE = 50,
    parameter int SIZE_W      = 16
)
(
    input  wire logic              ACLK,
    input  wire logic              ARESETn,
    // run control
    input  wire logic              fdtd_start_i,
    input  wire logic [ADDR_W-1:0] hy_base_i,
    input  wire logic [ADDR_W-1:0] ez_base_i,
    input  wire logic [SIZE_W-1:0] size_i,
    input  wire logic              ctrl_int_en_i,
    input  wire logic              cmd_clr_int_i,
    output logic                   status_busy_o,
    output logic                   status_int_pending_o,
    output logic                   int_o,
    // memory word port
    output mem_rd_req_t            mem_rd_o,
    input  wire logic              mem_rd_gnt_i,
    input  wire word_t             mem_rd_data_i,
    output mem_wr_req_t            mem_wr_o,
    input  wire logic              mem_wr_gnt_i,
    // field update engine
    input  wire logic              calc_hy_en_i,
    input  wire logic              calc_ez_en_i,
    input  wire logic              wrt_start_i,
    input  wire word_t             hy_new_i,
    input  wire word_t             ez_new_i,
    output word_t                  hy_old_o,
    output word_t                  ez_old_o,
    output logic                   rdvalid_hy_o,
    output logic                   rdvalid_ez_o,
    output logic                   wrtvalid_o,
    output logic                   calc_hy_flg_o,
    output logic                   calc_ez_flg_o,
    output logic                   buffer_end_o,
    output logic                   calc_hy_end_o,
    output logic                   calc_ez_end_o
);

    seq_cmd_t   cmd;
    word_addr_t rd_addr;
    word_addr_t wr_addr;
    logic       chunk_last;
    logic       run_empty;
    logic       rd_gnt;
    logic       wr_gnt;
    logic       field_done;
    field_e     done_field;
    addr_u      hy_base_u;
    addr_u      ez_base_u;

    // bases arrive word aligned
    assign hy_base_u.raw = hy_base_i;
    assign ez_base_u.raw = ez_base_i;

    //////////////////////////////
    // sequencing
    //////////////////////////////

    fdtd_seq_fsm u_fsm (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .fdtd_start_i  (fdtd_start_i),
        .calc_hy_en_i  (calc_hy_en_i),
        .calc_ez_en_i  (calc_ez_en_i),
        .wrt_start_i   (wrt_start_i),
        .rd_gnt_i      (rd_gnt),
        .wr_gnt_i      (wr_gnt),
        .chunk_last_i  (chunk_last),
        .run_empty_i   (run_empty),
        .cmd_o         (cmd),
        .calc_hy_flg_o (calc_hy_flg_o),
        .calc_ez_flg_o (calc_ez_flg_o),
        .buffer_end_o  (buffer_end_o),
        .busy_o        (status_busy_o),
        .field_done_o  (field_done),
        .done_field_o  (done_field)
    );

    fdtd_addr_gen #(
        .BUFFER_SIZE (BUFFER_SIZE),
        .SIZE_W      (SIZE_W)
    ) u_addr_gen (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .cmd_i        (cmd),
        .hy_word_i    (hy_base_u.f.word),
        .ez_word_i    (ez_base_u.f.word),
        .size_i       (size_i),
        .rd_gnt_i     (rd_gnt),
        .wr_gnt_i     (wr_gnt),
        .rd_addr_o    (rd_addr),
        .wr_addr_o    (wr_addr),
        .chunk_last_o (chunk_last),
        .run_empty_o  (run_empty)
    );

    //////////////////////////////
    // memory and engine side
    //////////////////////////////

    fdtd_word_port u_word_port (
        .cmd_i         (cmd),
        .rd_addr_i     (rd_addr),
        .wr_addr_i     (wr_addr),
        .hy_new_i      (hy_new_i),
        .ez_new_i      (ez_new_i),
        .mem_rd_gnt_i  (mem_rd_gnt_i),
        .mem_rd_data_i (mem_rd_data_i),
        .mem_wr_gnt_i  (mem_wr_gnt_i),
        .mem_rd_o      (mem_rd_o),
        .mem_wr_o      (mem_wr_o),
        .rd_gnt_o      (rd_gnt),
        .wr_gnt_o      (wr_gnt),
        .hy_old_o      (hy_old_o),
        .ez_old_o      (ez_old_o),
        .rdvalid_hy_o  (rdvalid_hy_o),
        .rdvalid_ez_o  (rdvalid_ez_o),
        .wrtvalid_o    (wrtvalid_o)
    );

    fdtd_status u_status (
        .ACLK                 (ACLK),
        .ARESETn              (ARESETn),
        .busy_i               (status_busy_o),
        .field_done_i         (field_done),
        .done_field_i         (done_field),
        .calc_hy_en_i         (calc_hy_en_i),
        .calc_ez_en_i         (calc_ez_en_i),
        .ctrl_int_en_i        (ctrl_int_en_i),
        .cmd_clr_int_i        (cmd_clr_int_i),
        .status_int_pending_o (status_int_pending_o),
        .int_o                (int_o),
        .calc_hy_end_o        (calc_hy_end_o),
        .calc_ez_end_o        (calc_ez_end_o)
    );

endmodule

`default_nettype wire

// File: fdtd_mem_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl_props
    import fdtd_pkg::*;
(
    input wire logic        ACLK,
    input wire logic        ARESETn,
    input wire mem_rd_req_t mem_rd_i,
    input wire mem_wr_req_t mem_wr_i,
    input wire logic        mem_rd_gnt_i,
    input wire logic        mem_wr_gnt_i,
    input wire logic        rdvalid_hy_i,
    input wire logic        rdvalid_ez_i
);

    // failed assertions so far
    int fire_cnt = 0;

    //////////////////////////////
    // request stability
    //////////////////////////////

    rd_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        mem_rd_i.req && !mem_rd_gnt_i |=> mem_rd_i.req && $stable(mem_rd_i.addr))
    else
    begin
        fire_cnt++;
        $error("read request dropped or moved before its grant");
    end

    // data also frozen while a write waits
    wr_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        mem_wr_i.req && !mem_wr_gnt_i |=>
            mem_wr_i.req && $stable(mem_wr_i.addr) && $stable(mem_wr_i.data))
    else
    begin
        fire_cnt++;
        $error("write request dropped or changed before its grant");
    end

    // ez strobes never overlap hy and wait out the phase settle cycle
    rd_one_field: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rdvalid_hy_i |-> !rdvalid_ez_i ##1 !rdvalid_ez_i)
    else
    begin
        fire_cnt++;
        $error("ez read strobe together with or right after a hy read strobe");
    end

endmodule

`default_nettype wire

// File: fdtd_mem_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl_tb
    import fdtd_pkg::*;
();

    localparam int    BUF_WORDS  = 4;
    localparam int    SIZE_W     = 16;
    localparam int    RUN_LIMIT  = 2000;
    localparam int    PEND_LIMIT = 4;
    localparam word_t FLIP       = 32'h5a5a_5a5a;

    // one run of the table
    typedef struct packed {
        logic [ADDR_W-1:0] hy_base;
        logic [ADDR_W-1:0] ez_base;
        logic [SIZE_W-1:0] size;
        field_e            field;
        logic              int_en;
        logic              exp_int;
    } row_t;

    logic              ACLK = 1'b0;
    logic              ARESETn;
    logic              start, int_en, clr_int, busy, pending, irq;
    logic [ADDR_W-1:0] hy_base, ez_base;
    logic [SIZE_W-1:0] size;
    mem_rd_req_t       mem_rd;
    mem_wr_req_t       mem_wr;
    logic              rd_gnt, wr_gnt;
    word_t             rd_data, hy_new, ez_new, hy_old, ez_old;
    logic              hy_en, ez_en, wrt_start;
    logic              rdvalid_hy, rdvalid_ez, wrtvalid;
    logic              hy_flg, ez_flg, buffer_end, hy_end, ez_end;

    row_t        runs [0:3];
    word_t       mem [0:255];
    word_t       golden [0:255];
    word_t       hy_seen [$];
    word_t       ez_seen [$];
    logic [31:0] lfsr_q;
    logic [31:0] pick;
    int          rd_delay, wr_delay, wr_pos, hy_flg_cnt, ez_flg_cnt;
    int          buf_end_cycles;
    logic        rd_armed, wr_armed, choice_taken, timed_out;
    field_e      cur_field, seen_field;
    int          n_checks, n_errors, i;

    fdtd_mem_ctrl #(
        .BUFFER_SIZE (BUF_WORDS),
        .SIZE_W      (SIZE_W)
    ) uut (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .fdtd_start_i (start), .hy_base_i (hy_base), .ez_base_i (ez_base),
        .size_i (size), .ctrl_int_en_i (int_en), .cmd_clr_int_i (clr_int),
        .status_busy_o (busy), .status_int_pending_o (pending), .int_o (irq),
        .mem_rd_o (mem_rd), .mem_rd_gnt_i (rd_gnt), .mem_rd_data_i (rd_data),
        .mem_wr_o (mem_wr), .mem_wr_gnt_i (wr_gnt),
        .calc_hy_en_i (hy_en), .calc_ez_en_i (ez_en), .wrt_start_i (wrt_start),
        .hy_new_i (hy_new), .ez_new_i (ez_new), .hy_old_o (hy_old), .ez_old_o (ez_old),
        .rdvalid_hy_o (rdvalid_hy), .rdvalid_ez_o (rdvalid_ez), .wrtvalid_o (wrtvalid),
        .calc_hy_flg_o (hy_flg), .calc_ez_flg_o (ez_flg), .buffer_end_o (buffer_end),
        .calc_hy_end_o (hy_end), .calc_ez_end_o (ez_end)
    );

    bind fdtd_word_port fdtd_mem_ctrl_props u_props (
        .ACLK         (fdtd_mem_ctrl_tb.ACLK),
        .ARESETn      (fdtd_mem_ctrl_tb.ARESETn),
        .mem_rd_i     (mem_rd_o),
        .mem_wr_i     (mem_wr_o),
        .mem_rd_gnt_i (mem_rd_gnt_i),
        .mem_wr_gnt_i (mem_wr_gnt_i),
        .rdvalid_hy_i (rdvalid_hy_o),
        .rdvalid_ez_i (rdvalid_ez_o)
    );

    always #10 ACLK = ~ACLK;

    //////////////////////////////
    // random source
    //////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
        else
            $display("ok  %s = %h", what, got);
    endtask

    task automatic check_field(input string what, input field_e got, input field_e exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %s expected %s", $time, what,
                     got.name(), exp.name());
        end
        else
            $display("ok  %s = %s", what, got.name());
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
        else
            $display("ok  %s = %b", what, got);
    endtask

    //////////////////////////////
    // memory and engine models
    //////////////////////////////

    // grants after 0 to 3 cycles, engine reacts to the buffer end
    always @(negedge ACLK)
    begin
        rd_gnt  = 1'b0;
        rd_data = '0;
        wr_gnt  = 1'b0;
        if (mem_rd.req)
        begin
            if (!rd_armed)
            begin
                draw_bits(2, pick);
                rd_delay = int'(pick[1:0]);
                rd_armed = 1'b1;
            end
            if (rd_delay == 0)
            begin
                rd_gnt   = 1'b1;
                rd_data  = mem[mem_rd.addr[9:2]];
                rd_armed = 1'b0;
            end
            else
                rd_delay--;
        end
        if (mem_wr.req)
        begin
            if (!wr_armed)
            begin
                draw_bits(2, pick);
                wr_delay = int'(pick[1:0]);
                wr_armed = 1'b1;
            end
            if (wr_delay == 0)
            begin
                wr_gnt   = 1'b1;
                wr_armed = 1'b0;
            end
            else
                wr_delay--;
        end
        wrt_start = 1'b0;
        if (choice_taken)
        begin
            hy_en        = 1'b0;
            ez_en        = 1'b0;
            wrt_start    = 1'b1;
            choice_taken = 1'b0;
        end
        else if (buffer_end)
        begin
            hy_en = (cur_field == FIELD_HY);
            ez_en = (cur_field == FIELD_EZ);
        end
        // new value for the next word to be written
        hy_new = (wr_pos < hy_seen.size()) ? hy_seen[wr_pos] ^ FLIP : '0;
        ez_new = (wr_pos < ez_seen.size()) ? ez_seen[wr_pos] ^ FLIP : '0;
    end

    // strobes are sampled before the edge updates the DUT
    always @(posedge ACLK)
    begin
        if (rdvalid_hy)
            hy_seen.push_back(hy_old);
        if (rdvalid_ez)
            ez_seen.push_back(ez_old);
        if (wrtvalid)
        begin
            mem[mem_wr.addr[9:2]] = mem_wr.data;
            wr_pos++;
        end
        // one cycle for the choice, one for the write start
        if (buffer_end)
            buf_end_cycles++;
        if (hy_flg)
        begin
            hy_flg_cnt++;
            seen_field   = FIELD_HY;
            choice_taken = 1'b1;
        end
        if (ez_flg)
        begin
            ez_flg_cnt++;
            seen_field   = FIELD_EZ;
            choice_taken = 1'b1;
        end
    end

    //////////////////////////////
    // run sequence
    //////////////////////////////

    task automatic wait_run_end(input int r);
        int n;
        n = 0;
        while (busy && n < RUN_LIMIT)
        begin
            @(negedge ACLK);
            n++;
        end
        if (busy)
        begin
            timed_out = 1'b1;
            $display("timeout: run %0d never finished, busy stayed high", r);
        end
    endtask

    task automatic wait_pending(input int r);
        int n;
        n = 0;
        while (!pending && n < PEND_LIMIT)
        begin
            @(negedge ACLK);
            n++;
        end
        if (!pending)
        begin
            timed_out = 1'b1;
            $display("timeout: run %0d ended but the interrupt never went pending", r);
        end
    endtask

    task automatic check_window(input int r, input string name, input int base_w,
                                input int n, input logic updated);
        word_t exp;
        for (int k = 0; k < n + 2; k++)
        begin
            exp = golden[base_w + k];
            if (updated && k < n)
                exp = exp ^ FLIP;
            check_word($sformatf("run %0d %s mem word %0d", r, name, k), mem[base_w + k], exp);
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   hy_w;
        int   ez_w;
        int   chunks;
        row    = runs[r];
        hy_w   = int'(row.hy_base >> 2);
        ez_w   = int'(row.ez_base >> 2);
        chunks = (int'(row.size) + BUF_WORDS - 1) / BUF_WORDS;
        @(negedge ACLK);
        golden = mem;
        hy_seen.delete();
        ez_seen.delete();
        wr_pos         = 0;
        hy_flg_cnt     = 0;
        ez_flg_cnt     = 0;
        buf_end_cycles = 0;
        cur_field      = row.field;
        hy_base        = row.hy_base;
        ez_base        = row.ez_base;
        size           = row.size;
        int_en         = row.int_en;
        start          = 1'b1;
        @(negedge ACLK);
        start = 1'b0;
        check_bit($sformatf("run %0d busy after start", r), busy, 1'b1);
        wait_run_end(r);
        if (timed_out)
            return;
        check_bit($sformatf("run %0d hy end flag", r), hy_end, row.field == FIELD_HY);
        check_bit($sformatf("run %0d ez end flag", r), ez_end, row.field == FIELD_EZ);
        wait_pending(r);
        if (timed_out)
            return;
        check_bit($sformatf("run %0d int", r), irq, row.exp_int);
        // read strobes in ascending address order
        check_word($sformatf("run %0d hy reads", r), hy_seen.size(), row.size);
        check_word($sformatf("run %0d ez reads", r), ez_seen.size(), row.size);
        for (int k = 0; k < int'(row.size) && k < hy_seen.size(); k++)
            check_word($sformatf("run %0d hy old %0d", r, k), hy_seen[k], golden[hy_w + k]);
        for (int k = 0; k < int'(row.size) && k < ez_seen.size(); k++)
            check_word($sformatf("run %0d ez old %0d", r, k), ez_seen[k], golden[ez_w + k]);
        check_word($sformatf("run %0d hy choices", r), hy_flg_cnt,
                   (row.field == FIELD_HY) ? chunks : 0);
        check_word($sformatf("run %0d ez choices", r), ez_flg_cnt,
                   (row.field == FIELD_EZ) ? chunks : 0);
        check_word($sformatf("run %0d buffer end cycles", r), buf_end_cycles, 2 * chunks);
        check_field($sformatf("run %0d chosen field", r), seen_field, row.field);
        check_window(r, "hy", hy_w, int'(row.size), row.field == FIELD_HY);
        check_window(r, "ez", ez_w, int'(row.size), row.field == FIELD_EZ);
        clr_int = 1'b1;
        @(negedge ACLK);
        clr_int = 1'b0;
        check_bit($sformatf("run %0d pending after clear", r), pending, 1'b0);
        check_bit($sformatf("run %0d int after clear", r), irq, 1'b0);
        // other field's enable hands the end flag off
        hy_en = (row.field == FIELD_EZ);
        ez_en = (row.field == FIELD_HY);
        @(negedge ACLK);
        hy_en = 1'b0;
        ez_en = 1'b0;
        check_bit($sformatf("run %0d end flag after hand off", r),
                  (row.field == FIELD_HY) ? hy_end : ez_end, 1'b0);
    endtask

    initial
    begin
        ARESETn        = 1'b0;
        start          = 1'b0;
        hy_base        = '0;
        ez_base        = '0;
        size           = '0;
        int_en         = 1'b0;
        clr_int        = 1'b0;
        rd_gnt         = 1'b0;
        rd_data        = '0;
        wr_gnt         = 1'b0;
        hy_en          = 1'b0;
        ez_en          = 1'b0;
        wrt_start      = 1'b0;
        hy_new         = '0;
        ez_new         = '0;
        rd_armed       = 1'b0;
        wr_armed       = 1'b0;
        choice_taken   = 1'b0;
        timed_out      = 1'b0;
        cur_field      = FIELD_HY;
        seen_field     = FIELD_HY;
        wr_pos         = 0;
        buf_end_cycles = 0;
        n_checks       = 0;
        n_errors       = 0;
        lfsr_q         = 32'hf8c;
        // hy base, ez base, size, field, int enable, expected int
        runs[0] = '{32'h0000_0000, 32'h0000_0100, 16'd4, FIELD_HY, 1'b1, 1'b1};
        runs[1] = '{32'h0000_0040, 32'h0000_0200, 16'd6, FIELD_EZ, 1'b0, 1'b0};
        runs[2] = '{32'h0000_0300, 32'h0000_0380, 16'd1, FIELD_HY, 1'b1, 1'b1};
        runs[3] = '{32'h0000_0080, 32'h0000_0180, 16'd6, FIELD_HY, 1'b1, 1'b1};
        for (i = 0; i < 256; i++)
        begin
            draw_bits(32, pick);
            mem[i] = pick;
        end
        repeat (3) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        check_bit("reset busy", busy, 1'b0);
        check_bit("reset pending", pending, 1'b0);
        check_bit("reset int", irq, 1'b0);
        check_bit("reset read request", mem_rd.req, 1'b0);
        check_bit("reset write request", mem_wr.req, 1'b0);
        check_bit("reset buffer end", buffer_end, 1'b0);
        for (i = 0; i < 4; i++)
        begin
            run_row(i);
            if (timed_out)
                break;
        end
        n_errors += uut.u_word_port.u_props.fire_cnt;
        $display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
                 uut.u_word_port.u_props.fire_cnt);
        if (n_errors == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
fdtd_pkg.sv
fdtd_seq_fsm.sv
fdtd_addr_gen.sv
fdtd_word_port.sv
fdtd_status.sv
fdtd_mem_ctrl.sv
fdtd_mem_ctrl_props.sv
fdtd_mem_ctrl_tb.sv

// File: Bender.yml
package:
  name: fdtd_mem_ctrl

sources:
  - files:
      - fdtd_pkg.sv
      - fdtd_seq_fsm.sv
      - fdtd_addr_gen.sv
      - fdtd_word_port.sv
      - fdtd_status.sv
      - fdtd_mem_ctrl.sv
  - target: test
    files:
      - fdtd_mem_ctrl_props.sv
      - fdtd_mem_ctrl_tb.sv
